// File: cache_bridge.f
logic/cache_bridge_pkg.sv
logic/req_capture.sv
logic/refill_sequencer.sv
logic/bus_master.sv
logic/cache_bridge.sv
testbench/tb_mem_model.sv
testbench/cache_bridge_assert.sv
testbench/tb_cache_bridge.sv

// File: logic/bus_master.sv
`default_nettype none

module bus_master
    import cache_bridge_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               issue,
    input  cache_req_t         issue_req,
    input  logic               bus_ready,
    input  logic               bus_done,
    input  logic [data_w-1:0]  bus_rword,
    input  logic [block_w-1:0] bus_rblock,
    input  logic               finish_icache,
    input  logic               finish_dcache,
    output bus_req_t           bus_req,
    output cache_resp_t        icache_resp,
    output cache_resp_t        dcache_resp
);

    mem_op_t            bus_op;
    cache_req_t         bus_data;
    logic [data_w-1:0]  rword_q;
    logic [block_w-1:0] rblock_q;
    logic [1:0]         finish_vec;
    logic [1:0]         done_q;
    logic [data_w-1:0]  resp_rword [2];
    logic [block_w-1:0] resp_rblock [2];

    // request stays on the bus until ready is sampled
    always_ff @(posedge clk) begin
        if (!rstn) begin
            bus_op <= op_none;
        end else if (issue) begin
            bus_op <= issue_req.op;
        end else if (bus_ready && (bus_op != op_none)) begin
            bus_op <= op_none;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            bus_data <= issue_req;
        end
    end

    always_comb begin
        bus_req.op     = bus_op;
        bus_req.addr   = bus_data.addr;
        bus_req.wword  = bus_data.wword;
        bus_req.wstrb  = bus_data.wstrb;
        bus_req.wblock = bus_data.wblock;
    end

    // read data arrives with bus_done
    always_ff @(posedge clk) begin
        if (bus_done) begin
            rword_q  <= bus_rword;
            rblock_q <= bus_rblock;
        end
    end

    // index 0 is icache, 1 is dcache, as in client_t
    assign finish_vec = {finish_dcache, finish_icache};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            done_q <= 2'b00;
        end else begin
            done_q <= finish_vec;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (finish_vec[i]) begin
                resp_rword[i]  <= rword_q;
                resp_rblock[i] <= rblock_q;
            end
        end
    end

    always_comb begin
        icache_resp.done   = done_q[client_icache];
        icache_resp.rword  = resp_rword[client_icache];
        icache_resp.rblock = resp_rblock[client_icache];
        dcache_resp.done   = done_q[client_dcache];
        dcache_resp.rword  = resp_rword[client_dcache];
        dcache_resp.rblock = resp_rblock[client_dcache];
    end

endmodule

`default_nettype wire

// File: logic/cache_bridge.sv
`default_nettype none

module cache_bridge
    import cache_bridge_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  cache_req_t         icache_req,
    input  cache_req_t         dcache_req,
    output cache_resp_t        icache_resp,
    output cache_resp_t        dcache_resp,
    output bus_req_t           bus_req,
    input  logic               bus_ready,
    input  logic               bus_done,
    input  logic [data_w-1:0]  bus_rword,
    input  logic [block_w-1:0] bus_rblock
);

    cache_req_t icache_held;
    cache_req_t dcache_held;
    logic       finish_icache;
    logic       finish_dcache;
    logic       issue;
    cache_req_t issue_req;

    req_capture u_icap (
        .clk    (clk),
        .rstn   (rstn),
        .req    (icache_req),
        .finish (finish_icache),
        .held   (icache_held)
    );

    req_capture u_dcap (
        .clk    (clk),
        .rstn   (rstn),
        .req    (dcache_req),
        .finish (finish_dcache),
        .held   (dcache_held)
    );

    refill_sequencer u_seq (
        .clk           (clk),
        .rstn          (rstn),
        .icache_held   (icache_held),
        .dcache_held   (dcache_held),
        .bus_ready     (bus_ready),
        .bus_done      (bus_done),
        .issue         (issue),
        .issue_req     (issue_req),
        .finish_icache (finish_icache),
        .finish_dcache (finish_dcache),
        .active_client ()
    );

    bus_master u_bus (
        .clk           (clk),
        .rstn          (rstn),
        .issue         (issue),
        .issue_req     (issue_req),
        .bus_ready     (bus_ready),
        .bus_done      (bus_done),
        .bus_rword     (bus_rword),
        .bus_rblock    (bus_rblock),
        .finish_icache (finish_icache),
        .finish_dcache (finish_dcache),
        .bus_req       (bus_req),
        .icache_resp   (icache_resp),
        .dcache_resp   (dcache_resp)
    );

endmodule

`default_nettype wire

// File: logic/cache_bridge_pkg.sv
`default_nettype none

package cache_bridge_pkg;

    // bus geometry
    localparam int addr_w  = 32;
    localparam int data_w  = 32;
    localparam int block_w = 128;
    localparam int strb_w  = 4;

    // none doubles as the idle / empty marker everywhere
    typedef enum logic [2:0] {
        op_none        = 3'd0,
        op_load_word   = 3'd1,
        op_load_block  = 3'd2,
        op_store_word  = 3'd3,
        op_store_block = 3'd4
    } mem_op_t;

    typedef enum logic {
        client_icache = 1'b0,
        client_dcache = 1'b1
    } client_t;

    typedef enum logic [1:0] {
        seq_idle   = 2'd0,
        seq_issue  = 2'd1,
        seq_wait   = 2'd2,
        seq_finish = 2'd3
    } seq_state_t;

    typedef struct packed {
        mem_op_t            op;
        logic [addr_w-1:0]  addr;
        logic [data_w-1:0]  wword;
        logic [strb_w-1:0]  wstrb;
        logic [block_w-1:0] wblock;
    } cache_req_t;

    // same layout as cache_req_t, bus side
    typedef struct packed {
        mem_op_t            op;
        logic [addr_w-1:0]  addr;
        logic [data_w-1:0]  wword;
        logic [strb_w-1:0]  wstrb;
        logic [block_w-1:0] wblock;
    } bus_req_t;

    typedef struct packed {
        logic               done;
        logic [data_w-1:0]  rword;
        logic [block_w-1:0] rblock;
    } cache_resp_t;

endpackage

`default_nettype wire

// File: logic/refill_sequencer.sv
`default_nettype none

module refill_sequencer
    import cache_bridge_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  cache_req_t icache_held,
    input  cache_req_t dcache_held,
    input  logic       bus_ready,
    input  logic       bus_done,
    output logic       issue,
    output cache_req_t issue_req,
    output logic       finish_icache,
    output logic       finish_dcache,
    output client_t    active_client
);

    seq_state_t state;
    seq_state_t state_next;
    logic       grant_valid;
    client_t    grant;
    logic       start;

    // dcache always wins over icache
    assign grant_valid = (dcache_held.op != op_none) || (icache_held.op != op_none);
    assign grant       = (dcache_held.op != op_none) ? client_dcache : client_icache;
    assign start       = (state == seq_idle) && grant_valid;

    always_comb begin
        state_next = state;
        case (state)
            seq_idle: begin
                if (grant_valid) begin
                    state_next = seq_issue;
                end
            end
            seq_issue: begin
                // bus_req is not on the bus yet while issue is high
                if (bus_ready && !issue) begin
                    state_next = seq_wait;
                end
            end
            seq_wait: begin
                if (bus_done) begin
                    state_next = seq_finish;
                end
            end
            seq_finish: begin
                state_next = seq_idle;
            end
            default: begin
                state_next = seq_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= seq_idle;
        end else begin
            state <= state_next;
        end
    end

    // one-cycle issue strobe and the granted client
    always_ff @(posedge clk) begin
        if (!rstn) begin
            issue         <= 1'b0;
            active_client <= client_icache;
        end else begin
            issue <= start;
            if (start) begin
                active_client <= grant;
            end
        end
    end

    // winning request, kept until the next grant
    always_ff @(posedge clk) begin
        if (start) begin
            if (grant == client_dcache) begin
                issue_req <= dcache_held;
            end else begin
                issue_req <= icache_held;
            end
        end
    end

    // finish goes only to the client that owns the transfer
    assign finish_icache = (state == seq_finish) && (active_client == client_icache);
    assign finish_dcache = (state == seq_finish) && (active_client == client_dcache);

endmodule

`default_nettype wire

// File: logic/req_capture.sv
`default_nettype none

module req_capture
    import cache_bridge_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  cache_req_t req,
    input  logic       finish,
    output cache_req_t held
);

    mem_op_t    held_op;
    cache_req_t held_data;

    // opcode tracks whether a request is pending
    always_ff @(posedge clk) begin
        if (!rstn) begin
            held_op <= op_none;
        end else if (req.op != op_none) begin
            held_op <= req.op;
        end else if (finish) begin
            held_op <= op_none;
        end
    end

    // address and write data of the pending request
    always_ff @(posedge clk) begin
        if (req.op != op_none) begin
            held_data <= req;
        end
    end

    always_comb begin
        held    = held_data;
        held.op = held_op;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_cache_bridge \
        -f cache_bridge.f -o tb_cache_bridge; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_cache_bridge)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "No errors"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: testbench/cache_bridge_assert.sv
`default_nettype none

module cache_bridge_assert
    import cache_bridge_pkg::*;
(
    input logic        clk,
    input logic        rstn,
    input bus_req_t    bus_req,
    input logic        bus_ready,
    input cache_resp_t icache_resp,
    input cache_resp_t dcache_resp
);
    timeunit 1ns;
    timeprecision 100ps;

    // request frozen while the memory stalls
    req_stable: assert property (@(posedge clk) disable iff (!rstn)
        ((bus_req.op != op_none) && !bus_ready) |=> $stable(bus_req))
        else $error("bus_req changed while bus_ready was low");

    done_onehot: assert property (@(posedge clk) disable iff (!rstn)
        !(icache_resp.done && dcache_resp.done))
        else $error("both caches got done in the same cycle");

    reset_idle: assert property (@(posedge clk) !rstn |=> (bus_req.op == op_none))
        else $error("bus_req opcode not none after reset");

endmodule

bind cache_bridge cache_bridge_assert u_assert (
    .clk         (clk),
    .rstn        (rstn),
    .bus_req     (bus_req),
    .bus_ready   (bus_ready),
    .icache_resp (icache_resp),
    .dcache_resp (dcache_resp)
);

`default_nettype wire

// File: testbench/tb_cache_bridge.sv
`default_nettype none

module tb_cache_bridge
    import cache_bridge_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic               clk;
    logic               rstn;
    cache_req_t         icache_req;
    cache_req_t         dcache_req;
    cache_resp_t        icache_resp;
    cache_resp_t        dcache_resp;
    bus_req_t           bus_req;
    logic               bus_ready;
    logic               bus_done;
    logic [data_w-1:0]  bus_rword;
    logic [block_w-1:0] bus_rblock;
    logic [data_w-1:0]  shadow [256];
    logic [31:0]        lcg_state;
    mem_op_t            first_op;

    cache_bridge dut (
        .clk         (clk),
        .rstn        (rstn),
        .icache_req  (icache_req),
        .dcache_req  (dcache_req),
        .icache_resp (icache_resp),
        .dcache_resp (dcache_resp),
        .bus_req     (bus_req),
        .bus_ready   (bus_ready),
        .bus_done    (bus_done),
        .bus_rword   (bus_rword),
        .bus_rblock  (bus_rblock)
    );

    tb_mem_model u_mem (
        .clk        (clk),
        .rstn       (rstn),
        .bus_req    (bus_req),
        .bus_ready  (bus_ready),
        .bus_done   (bus_done),
        .bus_rword  (bus_rword),
        .bus_rblock (bus_rblock)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected response; stores update the shadow memory first
    function automatic cache_resp_t expect_resp(input cache_req_t r);
        cache_resp_t e;
        logic [7:0]  w;
        logic [7:0]  b;
        w = r.addr[9:2];
        b = {r.addr[9:4], 2'b00};
        if (r.op == op_store_word) begin
            for (int i = 0; i < strb_w; i++) begin
                if (r.wstrb[i]) begin
                    shadow[w][8*i +: 8] = r.wword[8*i +: 8];
                end
            end
        end else if (r.op == op_store_block) begin
            shadow[b]         = r.wblock[31:0];
            shadow[b + 8'd1]  = r.wblock[63:32];
            shadow[b + 8'd2]  = r.wblock[95:64];
            shadow[b + 8'd3]  = r.wblock[127:96];
        end
        e.done   = 1'b1;
        e.rword  = shadow[w];
        e.rblock = {shadow[b + 8'd3], shadow[b + 8'd2], shadow[b + 8'd1], shadow[b]};
        return e;
    endfunction

    // upper half of memory for icache, lower half for dcache
    function automatic cache_req_t random_req(input logic upper, input logic loads_only);
        cache_req_t  r;
        logic [31:0] v;
        v      = lcg_next();
        r.addr = {22'd0, upper, v[24:18], 2'b00};
        if (loads_only) begin
            r.op = v[26] ? op_load_block : op_load_word;
        end else begin
            case (v[27:26])
                2'd0:    r.op = op_load_word;
                2'd1:    r.op = op_load_block;
                2'd2:    r.op = op_store_word;
                default: r.op = op_store_block;
            endcase
        end
        r.wstrb  = v[31:28];
        r.wword  = lcg_next();
        r.wblock = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        return r;
    endfunction

    task automatic abort_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_resp(input string name, input cache_resp_t got,
                              input cache_resp_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bus_op(input string name, input mem_op_t got, input mem_op_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_done(input client_t c, output cache_resp_t resp);
        for (int n = 0; n < 200; n++) begin
            @(posedge clk);
            resp = (c == client_dcache) ? dcache_resp : icache_resp;
            if (resp.done) begin
                return;
            end
        end
        $display("timeout: a cache waited too long for its done pulse");
        abort_run();
    endtask

    task automatic wait_bus_op(output mem_op_t op);
        for (int n = 0; n < 200; n++) begin
            @(posedge clk);
            op = bus_req.op;
            if (op != op_none) begin
                return;
            end
        end
        $display("timeout: no request appeared on the bus");
        abort_run();
    endtask

    // one-cycle request pulse, then wait for done and compare
    task automatic run_transfer(input client_t c, input cache_req_t r);
        cache_resp_t exp;
        cache_resp_t got;
        exp = expect_resp(r);
        @(posedge clk);
        if (c == client_dcache) begin
            dcache_req <= r;
        end else begin
            icache_req <= r;
        end
        @(posedge clk);
        if (c == client_dcache) begin
            dcache_req.op <= op_none;
        end else begin
            icache_req.op <= op_none;
        end
        wait_done(c, got);
        check_resp((c == client_dcache) ? "dcache_resp" : "icache_resp", got, exp);
    endtask

    initial begin
        cache_req_t r;
        rstn       <= 1'b0;
        icache_req <= '0;
        dcache_req <= '0;
        lcg_state = 32'd96;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = (32'(i) * 32'h01000193) ^ 32'h5a5a5a5a;
        end
        repeat (16) @(posedge clk);
        rstn <= 1'b1;

        // quiet bus and no done after reset
        repeat (4) begin
            @(posedge clk);
            check_bus_op("bus_req.op", bus_req.op, op_none);
            check_flag("icache_resp.done", icache_resp.done, 1'b0);
            check_flag("dcache_resp.done", dcache_resp.done, 1'b0);
        end

        // store word then load word, merged under the strobes
        r = '0;
        r.op = op_store_word;
        r.addr = 32'h40;
        r.wword = 32'hdeadbeef;
        r.wstrb = 4'b0101;
        run_transfer(client_dcache, r);
        r.op = op_load_word;
        run_transfer(client_dcache, r);

        // store block, then icache reads inside it
        r.op = op_store_block;
        r.addr = 32'h80;
        r.wblock = 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0;
        run_transfer(client_dcache, r);
        r.op = op_load_block;
        r.addr = 32'h88;
        run_transfer(client_icache, r);
        r.op = op_load_word;
        r.addr = 32'h84;
        run_transfer(client_icache, r);

        // same-cycle requests, dcache goes first
        r.op = op_load_block;
        r.addr = 32'h300;
        fork
            run_transfer(client_dcache, '{op: op_load_word, addr: 32'h48, default: '0});
            run_transfer(client_icache, r);
            wait_bus_op(first_op);
        join
        check_bus_op("bus_req.op", first_op, op_load_word);
        repeat (4) begin
            @(posedge clk);
            check_flag("icache_resp.done", icache_resp.done, 1'b0);
            check_flag("dcache_resp.done", dcache_resp.done, 1'b0);
        end

        fork
            repeat (40) run_transfer(client_dcache, random_req(1'b0, 1'b0));
            repeat (40) run_transfer(client_icache, random_req(1'b1, 1'b1));
        join

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
`default_nettype none

module tb_mem_model
    import cache_bridge_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  bus_req_t           bus_req,
    output logic               bus_ready,
    output logic               bus_done,
    output logic [data_w-1:0]  bus_rword,
    output logic [block_w-1:0] bus_rblock
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [data_w-1:0] mem [256];
    logic [31:0]       lcg_state;
    bus_req_t          req_q;
    logic [7:0]        widx;
    logic [7:0]        bidx;
    int                ready_wait;
    int                done_wait;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    initial begin
        logic [31:0] r;
        lcg_state = 32'd96;
        for (int i = 0; i < 256; i++) begin
            mem[i] = (32'(i) * 32'h01000193) ^ 32'h5a5a5a5a;
        end
        bus_ready  <= 1'b0;
        bus_done   <= 1'b0;
        bus_rword  <= '0;
        bus_rblock <= '0;
        forever begin
            @(posedge clk);
            if (rstn && (bus_req.op != op_none)) begin
                req_q      = bus_req;
                r          = lcg_next();
                ready_wait = int'(r[27:24]) % 6;
                done_wait  = int'(r[31:28]) % 6;
                repeat (ready_wait) @(posedge clk);
                bus_ready <= 1'b1;
                @(posedge clk);
                bus_ready <= 1'b0;
                repeat (done_wait) @(posedge clk);
                widx = req_q.addr[9:2];
                bidx = {req_q.addr[9:4], 2'b00};
                // stores land before the read data is returned
                if (req_q.op == op_store_word) begin
                    for (int b = 0; b < strb_w; b++) begin
                        if (req_q.wstrb[b]) begin
                            mem[widx][8*b +: 8] = req_q.wword[8*b +: 8];
                        end
                    end
                end else if (req_q.op == op_store_block) begin
                    for (int k = 0; k < 4; k++) begin
                        mem[bidx + 8'(k)] = req_q.wblock[32*k +: 32];
                    end
                end
                bus_done   <= 1'b1;
                bus_rword  <= mem[widx];
                bus_rblock <= {mem[bidx + 8'd3], mem[bidx + 8'd2], mem[bidx + 8'd1], mem[bidx]};
                @(posedge clk);
                bus_done <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire
